// ==== src/board_consts.svh ====
/* Board input constants
   Joystick chain timing, game reset stretch and status word bit layout */
`ifndef BOARD_CONSTS_SVH
`define BOARD_CONSTS_SVH

// clk_sys cycles per half period of joy_clk
`define JOY_DIV 4

// Chain frame length
// joy1 sits in 31..20, joy2 in 19..8, the sentinel byte in 7..0
`define JOY_FRAME_BITS 32

// Game reset is held this long after the last cause
`define GAME_RST_CYCLES 16

// Status word from the controller
`define ST_DIP_TEST 1
`define ST_DIP_PAUSE 2
`define ST_DIP_FLIP 3

// Low bit of a two bit field
`define ST_FXLEVEL_LO 4

// Sound chip disables where a set bit means off
`define ST_NO_FM 6
`define ST_NO_PSG 7

// Low bit of a two bit field
`define ST_ROTATE_LO 8

`endif

// ==== src/board_pkg.sv ====
/* Board input types
   Vector widths for joysticks and status plus the chain receiver states */
package board_pkg;

    // One active-low raw joystick from the chain
    // 0 right, 1 left, 2 down, 3 up, 4..9 buttons 1..6, 10 start, 11 coin
    typedef logic [11:0] joy_raw_t;

    // Joystick as the game core sees it, raw bits 9..0
    typedef logic [9:0] game_joy_t;

    // Controller status word
    typedef logic [31:0] status_t;

    // Effects level setting
    typedef logic [1:0] fxlevel_t;

    // Screen rotation setting
    typedef logic [1:0] rotate_t;

    // Whole shift-register frame with bit 31 arriving first
    typedef logic [31:0] joy_frame_t;

    // Chain receiver FSM
    typedef enum logic [1:0] {
        RX_IDLE,    // Gap between frames
        RX_LOAD,    // joy_load low while the chain latches buttons
        RX_SHIFT,   // Clocking bits out of the chain
        RX_DONE     // Frame handed over
    } rx_state_t;

endpackage

// ==== src/joy_if.sv ====
/* Joystick frame link
   One decoded chain frame passed from the receiver to the mapper */
`timescale 1ns/1ps

interface joy_if;
    import board_pkg::*;

    joy_raw_t joy1;     // Player 1 raw buttons
    joy_raw_t joy2;     // Player 2 raw buttons
    logic frame_stb;    // One cycle per finished frame
    logic frame_err;    // Sentinel mismatch valid with frame_stb

    modport rx (
        output joy1, joy2, frame_stb, frame_err
    );

    modport map (
        input joy1, joy2, frame_stb, frame_err
    );

endinterface

// ==== src/joy_serial_rx.sv ====
/* Joystick chain receiver
   Clocks a 74HC165 style chain, collects one frame and checks its sentinel */
`timescale 1ns/1ps
`include "board_consts.svh"

module joy_serial_rx (
    input  logic clk_sys,
    input  logic rst_n,
    input  logic joy_data,
    output logic joy_clk,
    output logic joy_load,
    joy_if.rx    jf
);
    import board_pkg::*;

    localparam int DIV_W = $clog2(2 * `JOY_DIV);
    localparam int BIT_W = $clog2(`JOY_FRAME_BITS);
    localparam logic [DIV_W-1:0] HALF_END = DIV_W'(`JOY_DIV - 1);
    localparam logic [DIV_W-1:0] PER_END = DIV_W'(2 * `JOY_DIV - 1);
    localparam logic [BIT_W-1:0] LAST_BIT = BIT_W'(`JOY_FRAME_BITS - 1);
    localparam int J1_LO = `JOY_FRAME_BITS - $bits(joy_raw_t);
    localparam int J2_LO = J1_LO - $bits(joy_raw_t);

    rx_state_t state;
    logic [DIV_W-1:0] div_cnt;  // Position inside a load or bit period
    logic [BIT_W-1:0] bit_cnt;
    joy_frame_t frame;
    logic sample_en;
    logic frame_end;

    // Sample at the rising joy_clk edge before the chain shifts
    assign sample_en = (state == RX_SHIFT) && (div_cnt == HALF_END);
    assign frame_end = (state == RX_SHIFT) && (div_cnt == PER_END) && (bit_cnt == LAST_BIT);

    always_ff @(posedge clk_sys) begin
        if (!rst_n) begin
            state <= RX_IDLE;
            div_cnt <= '0;
            bit_cnt <= '0;
            joy_load <= 1'b1;   // Chain idle while in reset
            joy_clk <= 1'b1;
            jf.frame_stb <= 1'b0;
        end else begin
            jf.frame_stb <= 1'b0;
            case (state)
                RX_IDLE: begin
                    joy_load <= 1'b0;
                    div_cnt <= '0;
                    state <= RX_LOAD;
                end
                RX_LOAD: begin
                    if (div_cnt == PER_END) begin
                        joy_load <= 1'b1;
                        joy_clk <= 1'b0;    // First bit period starts low
                        div_cnt <= '0;
                        bit_cnt <= '0;
                        state <= RX_SHIFT;
                    end else begin
                        div_cnt <= div_cnt + 1'b1;
                    end
                end
                RX_SHIFT: begin
                    div_cnt <= div_cnt + 1'b1;
                    if (div_cnt == HALF_END) begin
                        joy_clk <= 1'b1;
                    end
                    if (div_cnt == PER_END) begin
                        div_cnt <= '0;
                        if (bit_cnt == LAST_BIT) begin
                            jf.frame_stb <= 1'b1;   // joy_clk stays high
                            state <= RX_DONE;
                        end else begin
                            joy_clk <= 1'b0;
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
                RX_DONE: state <= RX_IDLE;
                default: state <= RX_IDLE;
            endcase
        end
    end

    // MSB first into the frame
    always_ff @(posedge clk_sys) begin
        if (sample_en) begin
            frame <= {frame[`JOY_FRAME_BITS-2:0], joy_data};
        end
    end

    // Split the frame and hold it until the next one ends
    always_ff @(posedge clk_sys) begin
        if (frame_end) begin
            jf.joy1 <= frame[J1_LO +: $bits(joy_raw_t)];
            jf.joy2 <= frame[J2_LO +: $bits(joy_raw_t)];
            jf.frame_err <= |frame[J2_LO-1:0];  // Sentinel is tied to zeros
        end
    end

endmodule

// ==== src/ctrl_map.sv ====
/* Control mapper
   Turns chain frames into game controls and decodes the status word */
`timescale 1ns/1ps
`include "board_consts.svh"

module ctrl_map #(
    parameter bit THREE_BUTTONS = 1'b0,
    parameter bit GAME_INPUTS_ACTIVE_LOW = 1'b1
) (
    input  logic                 clk_sys,
    input  logic                 rst_n,
    joy_if.map                   jf,
    input  board_pkg::status_t   status,
    output board_pkg::game_joy_t game_joystick1,
    output board_pkg::game_joy_t game_joystick2,
    output logic [1:0]           game_coin,
    output logic [1:0]           game_start,
    output logic                 game_service,
    output logic                 game_pause,
    output logic                 enable_fm,
    output logic                 enable_psg,
    output logic                 dip_test,
    output logic                 dip_pause,
    output logic                 dip_flip,
    output board_pkg::fxlevel_t  dip_fxlevel,
    output board_pkg::rotate_t   rotate,
    output logic                 joy_err
);
    import board_pkg::*;

    // Raw joystick bit positions
    localparam int BTN4 = 7;
    localparam int BTN6 = 9;
    localparam int START = 10;
    localparam int COIN = 11;

    // Flip the active-low raw levels when the core wants active high
    localparam game_joy_t JOY_INV = {$bits(game_joy_t){~GAME_INPUTS_ACTIVE_LOW}};
    localparam logic [1:0] PAIR_INV = {2{~GAME_INPUTS_ACTIVE_LOW}};
    localparam logic ONE_INV = ~GAME_INPUTS_ACTIVE_LOW;

    logic frame_ok;
    logic b6_now;
    logic b6_prev;      // Button 6 of player 1 in the last good frame
    logic start1_held;

    assign frame_ok = jf.frame_stb & ~jf.frame_err;
    assign b6_now = ~jf.joy1[BTN6];
    assign start1_held = ~jf.joy1[START];

    function automatic game_joy_t map_joy(input joy_raw_t raw);
        game_joy_t j;
        j = raw[$bits(game_joy_t)-1:0];
        if (THREE_BUTTONS) begin
            j[BTN6:BTN4] = '1;  // Released
        end
        return j ^ JOY_INV;
    endfunction

    always_ff @(posedge clk_sys) begin
        if (!rst_n) begin
            game_joystick1 <= ~JOY_INV;
            game_joystick2 <= ~JOY_INV;
            game_coin <= ~PAIR_INV;
            game_start <= ~PAIR_INV;
            game_service <= ~ONE_INV;
        end else if (frame_ok) begin
            game_joystick1 <= map_joy(jf.joy1);
            game_joystick2 <= map_joy(jf.joy2);
            game_coin <= {jf.joy2[COIN], jf.joy1[COIN]} ^ PAIR_INV;
            game_start <= {jf.joy2[START], jf.joy1[START]} ^ PAIR_INV;
            game_service <= (jf.joy1[COIN] | jf.joy2[COIN]) ^ ONE_INV; // Both coins down
        end
    end

    // Pause toggle on start + button 6 and the sticky error flag
    always_ff @(posedge clk_sys) begin
        if (!rst_n) begin
            game_pause <= 1'b0;
            b6_prev <= 1'b0;
            joy_err <= 1'b0;
        end else begin
            if (jf.frame_stb && jf.frame_err) begin
                joy_err <= 1'b1;
            end
            if (frame_ok) begin
                if (b6_now && !b6_prev && start1_held) begin
                    game_pause <= ~game_pause;
                end
                b6_prev <= b6_now;
            end
        end
    end

    always_ff @(posedge clk_sys) begin
        if (!rst_n) begin
            enable_fm <= 1'b1;
            enable_psg <= 1'b1;
            dip_test <= 1'b0;
            dip_pause <= 1'b0;
            dip_flip <= 1'b0;
            dip_fxlevel <= '0;
            rotate <= '0;
        end else begin
            enable_fm <= ~status[`ST_NO_FM];
            enable_psg <= ~status[`ST_NO_PSG];
            dip_test <= status[`ST_DIP_TEST];
            dip_pause <= status[`ST_DIP_PAUSE];
            dip_flip <= status[`ST_DIP_FLIP];
            dip_fxlevel <= status[`ST_FXLEVEL_LO +: $bits(fxlevel_t)];
            rotate <= status[`ST_ROTATE_LO +: $bits(rotate_t)];
        end
    end

endmodule

// ==== src/game_rst_gen.sv ====
/* Game reset generator
   Stretches reset requests, downloads and flip changes into one game reset */
`timescale 1ns/1ps
`include "board_consts.svh"

module game_rst_gen (
    input  logic clk_sys,
    input  logic rst_n,
    input  logic rst_req,
    input  logic downloading,
    input  logic dip_flip,
    output logic game_rst,
    output logic game_rst_n
);

    localparam int CNT_W = $clog2(`GAME_RST_CYCLES + 1);
    localparam logic [CNT_W-1:0] STRETCH = CNT_W'(`GAME_RST_CYCLES);

    logic [CNT_W-1:0] cnt;
    logic flip_last;
    logic flip_chg;
    logic cause;

    assign flip_chg = dip_flip ^ flip_last;    // Screen flip needs a fresh start
    assign cause = rst_req | downloading | flip_chg;

    // Plain delay of the flip setting
    always_ff @(posedge clk_sys) begin
        flip_last <= dip_flip;
    end

    always_ff @(posedge clk_sys) begin
        if (!rst_n) begin
            cnt <= STRETCH;
            game_rst <= 1'b1;
        end else begin
            if (cause) begin
                cnt <= STRETCH;     // Restart the stretch
            end else if (cnt != '0) begin
                cnt <= cnt - 1'b1;
            end
            game_rst <= cause || (cnt != '0);
        end
    end

    assign game_rst_n = ~game_rst;

endmodule

// ==== src/board_inputs.sv ====
/* Board input block
   Joystick chain, control mapping, status decode and game reset */
`timescale 1ns/1ps

module board_inputs #(
    parameter bit THREE_BUTTONS = 1'b0,
    parameter bit GAME_INPUTS_ACTIVE_LOW = 1'b1
) (
    input  logic                 clk_sys,
    input  logic                 rst_n,
    input  board_pkg::status_t   status,
    input  logic                 rst_req,
    input  logic                 downloading,
    // Joystick chain pins
    input  logic                 joy_data,
    output logic                 joy_clk,
    output logic                 joy_load,
    // Game controls
    output board_pkg::game_joy_t game_joystick1,
    output board_pkg::game_joy_t game_joystick2,
    output logic [1:0]           game_coin,
    output logic [1:0]           game_start,
    output logic                 game_service,
    output logic                 game_pause,
    output logic                 joy_err,
    // DIP and OSD settings
    output logic                 enable_fm,
    output logic                 enable_psg,
    output logic                 dip_test,
    output logic                 dip_pause,
    output logic                 dip_flip,     // A change restarts the game
    output board_pkg::fxlevel_t  dip_fxlevel,
    output board_pkg::rotate_t   rotate,
    // Game reset
    output logic                 game_rst,
    output logic                 game_rst_n
);

    joy_if jf();

    joy_serial_rx u_rx (
        .clk_sys  (clk_sys),
        .rst_n    (rst_n),
        .joy_data (joy_data),
        .joy_clk  (joy_clk),
        .joy_load (joy_load),
        .jf       (jf.rx)
    );

    ctrl_map #(
        .THREE_BUTTONS          (THREE_BUTTONS),
        .GAME_INPUTS_ACTIVE_LOW (GAME_INPUTS_ACTIVE_LOW)
    ) u_map (
        .clk_sys        (clk_sys),
        .rst_n          (rst_n),
        .jf             (jf.map),
        .status         (status),
        .game_joystick1 (game_joystick1),
        .game_joystick2 (game_joystick2),
        .game_coin      (game_coin),
        .game_start     (game_start),
        .game_service   (game_service),
        .game_pause     (game_pause),
        .enable_fm      (enable_fm),
        .enable_psg     (enable_psg),
        .dip_test       (dip_test),
        .dip_pause      (dip_pause),
        .dip_flip       (dip_flip),
        .dip_fxlevel    (dip_fxlevel),
        .rotate         (rotate),
        .joy_err        (joy_err)
    );

    game_rst_gen u_rst (
        .clk_sys     (clk_sys),
        .rst_n       (rst_n),
        .rst_req     (rst_req),
        .downloading (downloading),
        .dip_flip    (dip_flip),
        .game_rst    (game_rst),
        .game_rst_n  (game_rst_n)
    );

endmodule

// ==== test/tb_board_inputs.sv ====
/* Board input testbench
   Directed tests against a shift-register chain model and a status driver */
`timescale 1ns/1ps
`include "board_consts.svh"

module tb_board_inputs;
    import board_pkg::*;

    localparam int FRAME_CYCLES = 66 * `JOY_DIV + 2;
    localparam int TIMEOUT_CYCLES = 20 * FRAME_CYCLES + 200;
    localparam joy_raw_t IDLE_JOY = 12'hFFF;

    logic clk_sys;
    logic rst_n;
    status_t status;
    logic rst_req;
    logic downloading;
    logic joy_data = 1'b1;
    logic joy_clk;
    logic joy_load;
    game_joy_t game_joystick1;
    game_joy_t game_joystick2;
    logic [1:0] game_coin;
    logic [1:0] game_start;
    logic game_service;
    logic game_pause;
    logic joy_err;
    logic enable_fm;
    logic enable_psg;
    logic dip_test;
    logic dip_pause;
    logic dip_flip;
    fxlevel_t dip_fxlevel;
    rotate_t rotate;
    logic game_rst;
    logic game_rst_n;

    joy_frame_t pattern = {IDLE_JOY, IDLE_JOY, 8'h00};  // What the chain latches
    joy_frame_t chain = '0;
    logic joy_clk_q = 1'b1;
    integer seed = 32'h1a1a;
    int cycles = 0;
    int errors = 0;
    joy_raw_t last_j1;      // Last frame the mapper accepted
    joy_raw_t last_j2;

    board_inputs dut_i (
        .clk_sys(clk_sys), .rst_n(rst_n), .status(status),
        .rst_req(rst_req), .downloading(downloading),
        .joy_data(joy_data), .joy_clk(joy_clk), .joy_load(joy_load),
        .game_joystick1(game_joystick1), .game_joystick2(game_joystick2),
        .game_coin(game_coin), .game_start(game_start),
        .game_service(game_service), .game_pause(game_pause), .joy_err(joy_err),
        .enable_fm(enable_fm), .enable_psg(enable_psg), .dip_test(dip_test),
        .dip_pause(dip_pause), .dip_flip(dip_flip), .dip_fxlevel(dip_fxlevel),
        .rotate(rotate), .game_rst(game_rst), .game_rst_n(game_rst_n)
    );

    initial begin
        clk_sys = 1'b0;
        forever #50 clk_sys = ~clk_sys;
    end

    // 74HC165 chain with parallel load while joy_load is low
    always @(posedge clk_sys) begin
        if (!joy_load) begin
            chain <= pattern;
            joy_data <= pattern[31];
        end else if (joy_clk && !joy_clk_q) begin
            chain <= {chain[30:0], 1'b0};   // Shift on rising joy_clk
            joy_data <= chain[30];
        end
        joy_clk_q <= joy_clk;
    end

    always @(posedge clk_sys) begin
        cycles <= cycles + 1;
        if (cycles == TIMEOUT_CYCLES) begin
            $display("Timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("*** FAILED ***");
            $fatal(1, "Run stopped by the cycle limit");
        end
    end

    task automatic report_error(string msg);
        errors++;
        $display("ERROR at %0t ns: %s", $time, msg);
        $display("*** FAILED ***");
        $fatal(1, "Stopped at first mismatch");
    endtask

    task automatic check_joy(string what, game_joy_t got, game_joy_t exp);
        if (got !== exp) report_error($sformatf("%s is %h, expected %h", what, got, exp));
    endtask

    task automatic check_bit(string what, logic got, logic exp);
        if (got !== exp) report_error($sformatf("%s is %b, expected %b", what, got, exp));
    endtask

    task automatic check_fx(string what, fxlevel_t got, fxlevel_t exp);
        if (got !== exp) report_error($sformatf("%s is %h, expected %h", what, got, exp));
    endtask

    task automatic check_rot(string what, rotate_t got, rotate_t exp);
        if (got !== exp) report_error($sformatf("%s is %h, expected %h", what, got, exp));
    endtask

    task automatic check_count(string what, int got, int exp);
        if (got != exp) report_error($sformatf("%s is %0d, expected %0d", what, got, exp));
    endtask

    // Returns at the first negedge that sees joy_load low again
    task automatic wait_load_fall();
        logic was_high;
        was_high = 1'b0;
        @(negedge clk_sys);
        while (!(was_high && !joy_load)) begin
            was_high = joy_load;
            @(negedge clk_sys);
        end
    endtask

    // Called during a load so the chain picks the new pattern up in time
    task automatic send_frame(joy_raw_t j1, joy_raw_t j2, logic [7:0] sentinel);
        @(posedge clk_sys);
        pattern <= {j1, j2, sentinel};
        wait_load_fall();
    endtask

    task automatic expect_controls(joy_raw_t j1, joy_raw_t j2);
        logic both_coins;
        both_coins = !j1[11] && !j2[11];
        check_joy("game_joystick1", game_joystick1, j1[9:0]);
        check_joy("game_joystick2", game_joystick2, j2[9:0]);
        check_bit("game_coin[0]", game_coin[0], j1[11]);
        check_bit("game_coin[1]", game_coin[1], j2[11]);
        check_bit("game_start[0]", game_start[0], j1[10]);
        check_bit("game_start[1]", game_start[1], j2[10]);
        check_bit("game_service", game_service, !both_coins);
    endtask

    task automatic reset_values();
        expect_controls(IDLE_JOY, IDLE_JOY);
        check_bit("game_pause", game_pause, 1'b0);
        check_bit("game_rst", game_rst, 1'b1);
        check_bit("game_rst_n", game_rst_n, 1'b0);
        check_bit("joy_err", joy_err, 1'b0);
    endtask

    task automatic random_frames();
        logic [31:0] r;
        for (int i = 0; i < 8; i++) begin
            r = $random(seed);
            last_j1 = r[11:0];
            last_j2 = r[23:12];
            send_frame(last_j1, last_j2, 8'h00);
            expect_controls(last_j1, last_j2);
        end
        check_bit("joy_err", joy_err, 1'b0);
    endtask

    task automatic sentinel_error();
        logic [31:0] r;
        send_frame(~last_j1, ~last_j2, 8'h5A);
        check_bit("joy_err", joy_err, 1'b1);
        expect_controls(last_j1, last_j2);     // Bad frame is dropped
        r = $random(seed);
        last_j1 = r[11:0];
        last_j2 = r[23:12];
        send_frame(last_j1, last_j2, 8'h00);
        expect_controls(last_j1, last_j2);
        check_bit("joy_err", joy_err, 1'b1);   // Sticky
    endtask

    task automatic pause_toggle();
        logic p0;
        p0 = game_pause;
        send_frame(12'hBFF, IDLE_JOY, 8'h00);  // Start only
        check_bit("game_pause", game_pause, p0);
        send_frame(12'h9FF, IDLE_JOY, 8'h00);  // Start and button 6
        check_bit("game_pause", game_pause, !p0);
        send_frame(12'h9FF, IDLE_JOY, 8'h00);
        check_bit("game_pause", game_pause, !p0);
    endtask

    task automatic status_decode();
        status_t w;
        for (int i = 0; i < 8; i++) begin
            w = $random(seed);
            @(posedge clk_sys);
            status <= w;
            repeat (2) @(negedge clk_sys);
            check_bit("enable_fm", enable_fm, !w[`ST_NO_FM]);
            check_bit("enable_psg", enable_psg, !w[`ST_NO_PSG]);
            check_bit("dip_test", dip_test, w[`ST_DIP_TEST]);
            check_bit("dip_pause", dip_pause, w[`ST_DIP_PAUSE]);
            check_bit("dip_flip", dip_flip, w[`ST_DIP_FLIP]);
            check_fx("dip_fxlevel", dip_fxlevel, fxlevel_t'(w >> `ST_FXLEVEL_LO));
            check_rot("rotate", rotate, rotate_t'(w >> `ST_ROTATE_LO));
        end
    endtask

    // Cycles from the caller's edge until game_rst is seen low
    task automatic measure_stretch(string cause);
        int n;
        n = 0;
        @(negedge clk_sys);
        while (game_rst && n < 4 * `GAME_RST_CYCLES) begin
            @(negedge clk_sys);
            n++;
        end
        check_count({cause, " stretch"}, n, `GAME_RST_CYCLES + 1);
        check_bit("game_rst_n", game_rst_n, 1'b1);
    endtask

    task automatic reset_stretch();
        @(posedge clk_sys);
        status <= '0;
        rst_req <= 1'b1;
        repeat (3) @(posedge clk_sys);
        @(negedge clk_sys);
        check_bit("game_rst", game_rst, 1'b1);
        @(posedge clk_sys);
        rst_req <= 1'b0;
        measure_stretch("rst_req");
        @(posedge clk_sys);
        downloading <= 1'b1;
        repeat (5) @(posedge clk_sys);
        downloading <= 1'b0;
        measure_stretch("downloading");
        @(posedge clk_sys);
        status <= status ^ (32'h1 << `ST_DIP_FLIP);
        repeat (2) @(posedge clk_sys);  // dip_flip moves one cycle after status
        measure_stretch("flip");
    endtask

    initial begin
        rst_n = 1'b0;
        status = '0;
        rst_req = 1'b0;
        downloading = 1'b0;
        last_j1 = IDLE_JOY;
        last_j2 = IDLE_JOY;
        repeat (4) @(posedge clk_sys);
        rst_n <= 1'b1;
        @(negedge clk_sys);
        reset_values();
        wait_load_fall();
        random_frames();
        sentinel_error();
        pause_toggle();
        status_decode();
        reset_stretch();
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+src
src/board_pkg.sv
src/joy_if.sv
src/joy_serial_rx.sv
src/ctrl_map.sv
src/game_rst_gen.sv
src/board_inputs.sv
test/tb_board_inputs.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the board input testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f vlog.f --top-module tb_board_inputs \
    --Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -q -F '*** FAILED ***' sim.log; then
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi
exit 0
